/* cabinet_top.f */
source/arcade_pkg.sv
source/bridge_regs.sv
source/reset_stretch.sv
source/control_router.sv
source/video_formatter.sv
source/cabinet_top.sv
verif/cabinet_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cabinet testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cabinet_top.f --top-module cabinet_tb -o cabinet_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/cabinet_sim)
echo "$out"
echo "$out" | grep -q "^Finished with no errors$" && exit 0 || exit 1

/* source/arcade_pkg.sv */
//////////////////////////////////////////////////
// arcade cabinet glue package
// widths, bridge register map, timing constants
// and the structs shared by the cabinet blocks
//////////////////////////////////////////////////

package arcade_pkg;

    // bus and pad widths
    localparam int BRIDGE_W = 32;
    localparam int KEY_W = 16;
    localparam int JOY_W = 32;
    localparam int DIPS_W = 16;
    localparam int CTRL_W = 7;

    // full bridge addresses
    localparam logic [BRIDGE_W-1:0] ADDR_LIVES = 32'h2000_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_DIFFICULTY = 32'h3000_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_BONUS = 32'h4000_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_DEMO_SOUNDS = 32'h5000_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_RESET = 32'h8000_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_ANALOGIZER_ENA = 32'hF200_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_SNAC_CFG = 32'hF700_0000;

    // stick thresholds, idle sits near 0x80
    localparam logic [7:0] STICK_LOW = 8'h40;
    localparam logic [7:0] STICK_HIGH = 8'hC0;

    // adapter controller types
    localparam logic [4:0] SNAC_TYPE_NONE = 5'h00;
    localparam logic [4:0] SNAC_TYPE_ANALOG_A = 5'h12;
    localparam logic [4:0] SNAC_TYPE_ANALOG_B = 5'h13;

    // stretch lengths, shortened for simulation
    localparam int RESET_HOLD_CYCLES = 64;
    localparam int COIN_PULSE_CYCLES = 32;
    localparam int RESET_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);
    localparam int COIN_CNT_W = $clog2(COIN_PULSE_CYCLES + 1);

    // pad bitmap positions
    localparam int KEY_UP = 0;
    localparam int KEY_DOWN = 1;
    localparam int KEY_LEFT = 2;
    localparam int KEY_RIGHT = 3;
    localparam int KEY_A = 4;
    localparam int KEY_SELECT = 14;
    localparam int KEY_START = 15;

    // which adapter player lands on which pocket player
    typedef enum logic [1:0] {
        ASSIGN_P1_TO_P1 = 2'd0,
        ASSIGN_P1_TO_P2 = 2'd1,
        ASSIGN_BOTH_STRAIGHT = 2'd2,
        ASSIGN_BOTH_SWAPPED = 2'd3
    } snac_assign_e;

    typedef struct packed {
        logic [BRIDGE_W-1:0] addr;
        logic rd;
        logic wr;
        logic [BRIDGE_W-1:0] wr_data;
    } bridge_bus_t;

    typedef struct packed {
        logic [1:0] lives;
        logic [2:0] difficulty;
        logic [2:0] bonus;
        logic demo_sounds;
    } dip_cfg_t;

    // 8 bits, also the read-back layout
    typedef struct packed {
        logic [4:0] cont_type;
        snac_assign_e assignment;
        logic blank_screen;
    } snac_cfg_t;

    typedef struct packed {
        logic [11:0] rgb12;
        logic hblank;
        logic vblank;
        logic hs;
        logic vs;
    } core_video_t;

    typedef struct packed {
        logic [23:0] rgb24;
        logic de;
        logic hs;
        logic vs;
    } pocket_video_t;

endpackage

/* source/bridge_regs.sv */
//////////////////////////////////////////////////
// bridge configuration registers
// dip settings, adapter enable, snac settings and
// the soft reset toggle, plus the read-back mux
//////////////////////////////////////////////////

`timescale 1ns/10ps

module bridge_regs (
    input  logic                                clk_74a,
    input  logic                                rst,
    input  arcade_pkg::bridge_bus_t             bus,
    output logic [arcade_pkg::BRIDGE_W-1:0]     rd_data,
    output arcade_pkg::dip_cfg_t                dips,
    output arcade_pkg::snac_cfg_t               snac_cfg,
    output logic                                analogizer_ena,
    output logic                                reset_toggle
);

    //////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////

    // full address compare, host broadcasts writes to every device
    always_ff @(posedge clk_74a) begin
        if (rst) begin
            dips <= '0;
            snac_cfg <= '0;
            analogizer_ena <= 1'b0;
            reset_toggle <= 1'b0;
        end else if (bus.wr) begin
            case (bus.addr)
                arcade_pkg::ADDR_LIVES: begin
                    dips.lives <= bus.wr_data[1:0];
                end
                arcade_pkg::ADDR_DIFFICULTY: begin
                    dips.difficulty <= bus.wr_data[2:0];
                end
                arcade_pkg::ADDR_BONUS: begin
                    dips.bonus <= bus.wr_data[2:0];
                end
                arcade_pkg::ADDR_DEMO_SOUNDS: begin
                    dips.demo_sounds <= bus.wr_data[0];
                end
                arcade_pkg::ADDR_ANALOGIZER_ENA: begin
                    analogizer_ena <= bus.wr_data[0];
                end
                arcade_pkg::ADDR_SNAC_CFG: begin
                    // cont_type, assignment, blank_screen from bit 7 down
                    snac_cfg <= arcade_pkg::snac_cfg_t'(bus.wr_data[7:0]);
                end
                arcade_pkg::ADDR_RESET: begin
                    // any write flips it, data ignored
                    reset_toggle <= ~reset_toggle;
                end
                default: begin
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // read-back mux
    //////////////////////////////////////////////////

    // zero latency, follows addr directly
    always_comb begin
        rd_data = '0;
        case (bus.addr)
            arcade_pkg::ADDR_ANALOGIZER_ENA: begin
                rd_data[0] = analogizer_ena;
            end
            arcade_pkg::ADDR_SNAC_CFG: begin
                rd_data[7:0] = snac_cfg;
            end
            default: begin
                // dips and reset are write only
                rd_data = '0;
            end
        endcase
    end

endmodule

/* source/cabinet_top.sv */
//////////////////////////////////////////////////
// cabinet glue top level
// joins the bridge registers, reset stretcher,
// controller router and video formatter
//////////////////////////////////////////////////

`timescale 1ns/10ps

module cabinet_top (
    input  logic                                clk_74a,
    input  logic                                rst,
    input  arcade_pkg::bridge_bus_t             bridge,
    output logic [arcade_pkg::BRIDGE_W-1:0]     bridge_rd_data,
    input  logic [arcade_pkg::KEY_W-1:0]        cont1_key,
    input  logic [arcade_pkg::KEY_W-1:0]        cont2_key,
    input  logic [arcade_pkg::KEY_W-1:0]        snac_p1_btn,
    input  logic [arcade_pkg::JOY_W-1:0]        snac_p1_joy,
    input  logic [arcade_pkg::KEY_W-1:0]        snac_p2_btn,
    input  logic [arcade_pkg::JOY_W-1:0]        snac_p2_joy,
    input  arcade_pkg::core_video_t             core_video,
    output logic [arcade_pkg::DIPS_W-1:0]       game_dips,
    output logic [arcade_pkg::CTRL_W-1:0]       game_controls,
    output logic [arcade_pkg::KEY_W-1:0]        p2_controls,
    output logic                                core_reset,
    output arcade_pkg::pocket_video_t           pocket_video
);

    arcade_pkg::dip_cfg_t dips;
    arcade_pkg::snac_cfg_t snac_cfg;
    logic analogizer_ena;
    logic reset_toggle;

    bridge_regs regs0 (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .bus            (bridge),
        .rd_data        (bridge_rd_data),
        .dips           (dips),
        .snac_cfg       (snac_cfg),
        .analogizer_ena (analogizer_ena),
        .reset_toggle   (reset_toggle)
    );

    reset_stretch rst_stretch0 (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .reset_toggle   (reset_toggle),
        .core_reset     (core_reset)
    );

    control_router router0 (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .snac_cfg       (snac_cfg),
        .analogizer_ena (analogizer_ena),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .snac_p1_btn    (snac_p1_btn),
        .snac_p1_joy    (snac_p1_joy),
        .snac_p2_btn    (snac_p2_btn),
        .snac_p2_joy    (snac_p2_joy),
        .game_controls  (game_controls),
        .p2_controls    (p2_controls)
    );

    video_formatter video0 (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .core_video     (core_video),
        .analogizer_ena (analogizer_ena),
        .blank_screen   (snac_cfg.blank_screen),
        .pocket_video   (pocket_video)
    );

    // dip switch layout the game core expects, spare bits low
    assign game_dips = {dips.demo_sounds, 1'b0, dips.lives, 6'b0,
                        dips.difficulty, dips.bonus};

endmodule

/* source/control_router.sv */
//////////////////////////////////////////////////
// controller routing
// handheld or adapter pads, stick to dpad, and the
// coin press stretched into a long pulse
//////////////////////////////////////////////////

`timescale 1ns/10ps

module control_router (
    input  logic                                clk_74a,
    input  logic                                rst,
    input  arcade_pkg::snac_cfg_t               snac_cfg,
    input  logic                                analogizer_ena,
    input  logic [arcade_pkg::KEY_W-1:0]        cont1_key,
    input  logic [arcade_pkg::KEY_W-1:0]        cont2_key,
    input  logic [arcade_pkg::KEY_W-1:0]        snac_p1_btn,
    input  logic [arcade_pkg::JOY_W-1:0]        snac_p1_joy,
    input  logic [arcade_pkg::KEY_W-1:0]        snac_p2_btn,
    input  logic [arcade_pkg::JOY_W-1:0]        snac_p2_joy,
    output logic [arcade_pkg::CTRL_W-1:0]       game_controls,
    output logic [arcade_pkg::KEY_W-1:0]        p2_controls
);

    logic snac_is_analog;
    logic snac_off;
    logic [arcade_pkg::KEY_W-1:0] snac_p1_fix;
    logic [arcade_pkg::KEY_W-1:0] snac_p2_fix;
    logic [arcade_pkg::KEY_W-1:0] p1_next;
    logic [arcade_pkg::KEY_W-1:0] p2_next;
    logic [arcade_pkg::KEY_W-1:0] p1_controls;
    logic coin_prev;
    logic [arcade_pkg::COIN_CNT_W-1:0] coin_cnt;

    //////////////////////////////////////////////////
    // direction fix
    //////////////////////////////////////////////////

    // left stick only, x in the low byte and y above it
    function automatic logic [arcade_pkg::KEY_W-1:0] fix_dirs(
        input logic [arcade_pkg::KEY_W-1:0] btn,
        input logic [arcade_pkg::JOY_W-1:0] joy,
        input logic analog
    );
        logic [arcade_pkg::KEY_W-1:0] word;
        logic [7:0] stick_x;
        logic [7:0] stick_y;
        word = btn;
        stick_x = joy[7:0];
        stick_y = joy[15:8];
        if (analog) begin
            // dead zone between the two thresholds
            word[arcade_pkg::KEY_UP] = stick_y < arcade_pkg::STICK_LOW;
            word[arcade_pkg::KEY_DOWN] = stick_y > arcade_pkg::STICK_HIGH;
            word[arcade_pkg::KEY_LEFT] = stick_x < arcade_pkg::STICK_LOW;
            word[arcade_pkg::KEY_RIGHT] = stick_x > arcade_pkg::STICK_HIGH;
        end
        return word;
    endfunction

    assign snac_is_analog = (snac_cfg.cont_type == arcade_pkg::SNAC_TYPE_ANALOG_A) ||
                            (snac_cfg.cont_type == arcade_pkg::SNAC_TYPE_ANALOG_B);
    assign snac_off = !analogizer_ena || (snac_cfg.cont_type == arcade_pkg::SNAC_TYPE_NONE);
    assign snac_p1_fix = fix_dirs(snac_p1_btn, snac_p1_joy, snac_is_analog);
    assign snac_p2_fix = fix_dirs(snac_p2_btn, snac_p2_joy, snac_is_analog);

    //////////////////////////////////////////////////
    // player routing
    //////////////////////////////////////////////////

    always_comb begin
        // handheld pads unless the adapter is live
        p1_next = cont1_key;
        p2_next = cont2_key;
        if (!snac_off) begin
            case (snac_cfg.assignment)
                arcade_pkg::ASSIGN_P1_TO_P1: begin
                    p1_next = snac_p1_fix;
                    p2_next = cont1_key;
                end
                arcade_pkg::ASSIGN_P1_TO_P2: begin
                    // raw buttons here, stick not applied
                    p1_next = cont1_key;
                    p2_next = snac_p1_btn;
                end
                arcade_pkg::ASSIGN_BOTH_STRAIGHT: begin
                    p1_next = snac_p1_fix;
                    p2_next = snac_p2_fix;
                end
                arcade_pkg::ASSIGN_BOTH_SWAPPED: begin
                    p1_next = snac_p2_fix;
                    p2_next = snac_p1_fix;
                end
            endcase
        end
    end

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else begin
            p1_controls <= p1_next;
            p2_controls <= p2_next;
        end
    end

    //////////////////////////////////////////////////
    // coin stretcher
    //////////////////////////////////////////////////

    // fires on release of select, one pulse at a time
    always_ff @(posedge clk_74a) begin
        if (rst) begin
            coin_prev <= 1'b0;
            coin_cnt <= '0;
        end else begin
            coin_prev <= p1_controls[arcade_pkg::KEY_SELECT];
            if (coin_cnt != '0) begin
                coin_cnt <= coin_cnt - 1'b1;
            end else if (coin_prev && !p1_controls[arcade_pkg::KEY_SELECT]) begin
                coin_cnt <= arcade_pkg::COIN_CNT_W'(arcade_pkg::COIN_PULSE_CYCLES);
            end
        end
    end

    // up, down, left, right, a, start, coin from the msb down
    assign game_controls = {
        p1_controls[arcade_pkg::KEY_UP],
        p1_controls[arcade_pkg::KEY_DOWN],
        p1_controls[arcade_pkg::KEY_LEFT],
        p1_controls[arcade_pkg::KEY_RIGHT],
        p1_controls[arcade_pkg::KEY_A],
        p1_controls[arcade_pkg::KEY_START],
        coin_cnt != '0
    };

    a_coin_bounded: assert property (@(posedge clk_74a) disable iff (rst)
        coin_cnt <= arcade_pkg::COIN_CNT_W'(arcade_pkg::COIN_PULSE_CYCLES));

endmodule

/* source/reset_stretch.sv */
//////////////////////////////////////////////////
// soft reset stretcher
// each toggle edge gives a fixed-length core reset
//////////////////////////////////////////////////

`timescale 1ns/10ps

module reset_stretch (
    input  logic clk_74a,
    input  logic rst,
    input  logic reset_toggle,
    output logic core_reset
);

    logic toggle_prev;
    logic [arcade_pkg::RESET_CNT_W-1:0] hold_cnt;

    // counter loads full length, output high while nonzero
    always_ff @(posedge clk_74a) begin
        if (rst) begin
            toggle_prev <= 1'b0;
            hold_cnt <= '0;
        end else begin
            // prev always follows, so a toggle mid-stretch is lost
            toggle_prev <= reset_toggle;
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end else if (reset_toggle != toggle_prev) begin
                hold_cnt <= arcade_pkg::RESET_CNT_W'(arcade_pkg::RESET_HOLD_CYCLES);
            end
        end
    end

    // hard reset passes straight to the core
    assign core_reset = rst | (hold_cnt != '0);

    // stretch never longer than the hold length
    a_hold_bounded: assert property (@(posedge clk_74a) disable iff (rst)
        hold_cnt <= arcade_pkg::RESET_CNT_W'(arcade_pkg::RESET_HOLD_CYCLES));

endmodule

/* source/video_formatter.sv */
//////////////////////////////////////////////////
// video output formatter
// 12-bit to 24-bit colour, data enable from the
// blanking signals, screen blank, sync edge pulses
//////////////////////////////////////////////////

`timescale 1ns/10ps

module video_formatter (
    input  logic                        clk_74a,
    input  logic                        rst,
    input  arcade_pkg::core_video_t     core_video,
    input  logic                        analogizer_ena,
    input  logic                        blank_screen,
    output arcade_pkg::pocket_video_t   pocket_video
);

    logic active;
    logic hide_pixel;
    logic [23:0] rgb_wide;
    logic hs_prev;
    logic vs_prev;

    assign active = !(core_video.hblank || core_video.vblank);
    // handheld screen goes dark while the adapter drives a crt
    assign hide_pixel = blank_screen && analogizer_ena;
    // nibble repeat so 0xf maps to full 0xff
    assign rgb_wide = {{2{core_video.rgb12[11:8]}},
                       {2{core_video.rgb12[7:4]}},
                       {2{core_video.rgb12[3:0]}}};

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            pocket_video <= '0;
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
        end else begin
            pocket_video.de <= active;
            if (active && !hide_pixel) begin
                pocket_video.rgb24 <= rgb_wide;
            end else begin
                pocket_video.rgb24 <= '0;
            end
            // rising edge only, one cycle wide
            pocket_video.hs <= core_video.hs && !hs_prev;
            pocket_video.vs <= core_video.vs && !vs_prev;
            hs_prev <= core_video.hs;
            vs_prev <= core_video.vs;
        end
    end

    // scaler must never see colour outside the active area
    a_blank_black: assert property (@(posedge clk_74a) disable iff (rst)
        !pocket_video.de |-> (pocket_video.rgb24 == '0));

endmodule

/* verif/cabinet_tb.sv */
//////////////////////////////////////////////////
// cabinet glue testbench
// registers, soft reset, routing, coin and video
//////////////////////////////////////////////////

`timescale 1ns/10ps

module cabinet_tb;

    localparam int TIMEOUT_CYCLES = 4000;

    logic clk_74a;
    logic rst;
    arcade_pkg::bridge_bus_t bridge;
    logic [31:0] bridge_rd_data;
    logic [15:0] cont1_key;
    logic [15:0] cont2_key;
    logic [15:0] snac_p1_btn;
    logic [31:0] snac_p1_joy;
    logic [15:0] snac_p2_btn;
    logic [31:0] snac_p2_joy;
    arcade_pkg::core_video_t core_video;
    logic [15:0] game_dips;
    logic [6:0] game_controls;
    logic [15:0] p2_controls;
    logic core_reset;
    arcade_pkg::pocket_video_t pocket_video;

    logic [31:0] lfsr_state;
    int errors;
    int cycles;
    int test_start_errors;
    logic prev_hs;
    logic prev_vs;

    cabinet_top dut0 (
        .clk_74a(clk_74a), .rst(rst), .bridge(bridge), .bridge_rd_data(bridge_rd_data),
        .cont1_key(cont1_key), .cont2_key(cont2_key),
        .snac_p1_btn(snac_p1_btn), .snac_p1_joy(snac_p1_joy),
        .snac_p2_btn(snac_p2_btn), .snac_p2_joy(snac_p2_joy),
        .core_video(core_video), .game_dips(game_dips), .game_controls(game_controls),
        .p2_controls(p2_controls), .core_reset(core_reset), .pocket_video(pocket_video)
    );

    // 4 ns clock
    always #2 clk_74a = ~clk_74a;

    // run limit
    always @(posedge clk_74a) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // random source and reference models
    //////////////////////////////////////////////////

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [15:0] exp_dips(input logic [1:0] l, input logic [2:0] d,
                                             input logic [2:0] b, input logic s);
        logic [15:0] r;
        r = '0;
        r[15] = s;
        r[13:12] = l;
        r[5:3] = d;
        r[2:0] = b;
        return r;
    endfunction

    // stick below 0x40 or above 0xc0 sets a direction
    function automatic logic [15:0] stick_dirs(input logic [15:0] btn, input logic [31:0] joy,
                                               input logic analog);
        logic [15:0] r;
        r = btn;
        if (analog) begin
            r[0] = joy[15:8] < 8'h40;
            r[1] = joy[15:8] > 8'hC0;
            r[2] = joy[7:0] < 8'h40;
            r[3] = joy[7:0] > 8'hC0;
        end
        return r;
    endfunction

    // player 1 word in the top half, player 2 below
    function automatic logic [31:0] exp_route(input logic ena, input logic [7:0] cfg,
        input logic [15:0] c1, input logic [15:0] c2, input logic [15:0] b1,
        input logic [31:0] j1, input logic [15:0] b2, input logic [31:0] j2);
        logic analog;
        logic [15:0] f1;
        logic [15:0] f2;
        analog = (cfg[7:3] == 5'h12) || (cfg[7:3] == 5'h13);
        f1 = stick_dirs(b1, j1, analog);
        f2 = stick_dirs(b2, j2, analog);
        if (!ena || cfg[7:3] == 5'h00) begin
            return {c1, c2};
        end
        case (cfg[2:1])
            2'd0: return {f1, c1};
            2'd1: return {c1, b1};
            2'd2: return {f1, f2};
            default: return {f2, f1};
        endcase
    endfunction

    function automatic arcade_pkg::pocket_video_t exp_pixel(input arcade_pkg::core_video_t cv,
        input logic ph, input logic pv, input logic hide);
        arcade_pkg::pocket_video_t r;
        r.de = !cv.hblank && !cv.vblank;
        r.rgb24 = '0;
        if (r.de && !hide) begin
            r.rgb24 = {cv.rgb12[11:8], cv.rgb12[11:8], cv.rgb12[7:4], cv.rgb12[7:4],
                       cv.rgb12[3:0], cv.rgb12[3:0]};
        end
        r.hs = cv.hs && !ph;
        r.vs = cv.vs && !pv;
        return r;
    endfunction

    //////////////////////////////////////////////////
    // bus helpers
    //////////////////////////////////////////////////

    // single-cycle strobe, returns on the falling edge after the write lands
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_74a);
        bridge.addr = addr;
        bridge.wr_data = data;
        bridge.wr = 1'b1;
        @(negedge clk_74a);
        bridge.wr = 1'b0;
    endtask

    task automatic report_fail(input string msg);
        errors = errors + 1;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    //////////////////////////////////////////////////
    // stimulus and compare
    //////////////////////////////////////////////////

    initial begin
        logic [1:0] lives;
        logic [2:0] diff;
        logic [2:0] bonus;
        logic demo;
        logic [7:0] cfg;
        logic [7:0] cfg_list [10];
        logic [31:0] exp_r;
        logic [31:0] raw;
        logic blank;
        logic ena;
        int high;
        arcade_pkg::pocket_video_t exp_v;

        clk_74a = 1'b0;
        rst = 1'b1;
        bridge = '0;
        cont1_key = '0;
        cont2_key = '0;
        snac_p1_btn = '0;
        snac_p1_joy = '0;
        snac_p2_btn = '0;
        snac_p2_joy = '0;
        core_video = '0;
        lfsr_state = 32'h4792_d98e;
        errors = 0;
        cycles = 0;
        test_start_errors = 0;
        prev_hs = 1'b0;
        prev_vs = 1'b0;
        repeat (16) @(negedge clk_74a);
        rst = 1'b0;

        // registers and read-back
        for (int i = 0; i < 4; i++) begin
            lives = 2'(rand_bits(2));
            diff = 3'(rand_bits(3));
            bonus = 3'(rand_bits(3));
            demo = 1'(rand_bits(1));
            cfg = 8'(rand_bits(8));
            write_reg(arcade_pkg::ADDR_LIVES, {30'b0, lives});
            write_reg(arcade_pkg::ADDR_DIFFICULTY, {29'b0, diff});
            write_reg(arcade_pkg::ADDR_BONUS, {29'b0, bonus});
            write_reg(arcade_pkg::ADDR_DEMO_SOUNDS, {31'b0, demo});
            write_reg(arcade_pkg::ADDR_ANALOGIZER_ENA, {31'b0, cfg[0]});
            write_reg(arcade_pkg::ADDR_SNAC_CFG, {24'b0, cfg});
            if (game_dips !== exp_dips(lives, diff, bonus, demo)) report_fail("game_dips wrong");
            bridge.addr = arcade_pkg::ADDR_SNAC_CFG;
            #1;
            if (bridge_rd_data !== {24'b0, cfg}) report_fail("snac cfg read-back wrong");
            bridge.addr = arcade_pkg::ADDR_ANALOGIZER_ENA;
            #1;
            if (bridge_rd_data !== {31'b0, cfg[0]}) report_fail("enable read-back wrong");
            bridge.addr = 32'h6000_0000;
            #1;
            if (bridge_rd_data !== 32'b0) report_fail("unmapped address not zero");
        end
        end_test("registers");

        // soft reset, second pass toggles again mid-stretch
        for (int pass = 0; pass < 2; pass++) begin
            write_reg(arcade_pkg::ADDR_RESET, 32'h0);
            high = 0;
            for (int c = 0; c < 150; c++) begin
                @(negedge clk_74a);
                bridge.wr = 1'b0;
                if (core_reset) high = high + 1;
                if (pass == 1 && high == 10 && core_reset) begin
                    bridge.addr = arcade_pkg::ADDR_RESET;
                    bridge.wr = 1'b1;
                end
                if (high > 0 && !core_reset) break;
            end
            if (high != 64) report_fail($sformatf("core_reset high %0d cycles", high));
        end
        end_test("soft reset");

        // routing over off, none, analog and digital types, all assignments
        cfg_list = '{8'h00, 8'h01, 8'h90, 8'h92, 8'h94, 8'h96, 8'h28, 8'h2A, 8'h2C, 8'h2E};
        for (int k = 0; k < 10; k++) begin
            write_reg(arcade_pkg::ADDR_ANALOGIZER_ENA, {31'b0, k != 0});
            write_reg(arcade_pkg::ADDR_SNAC_CFG, {24'b0, cfg_list[k]});
            for (int i = 0; i < 20; i++) begin
                cont1_key = 16'(rand_bits(16));
                cont2_key = 16'(rand_bits(16));
                snac_p1_btn = 16'(rand_bits(16));
                snac_p1_joy = rand_bits(32);
                snac_p2_btn = 16'(rand_bits(16));
                snac_p2_joy = rand_bits(32);
                exp_r = exp_route(k != 0, cfg_list[k], cont1_key, cont2_key, snac_p1_btn,
                                  snac_p1_joy, snac_p2_btn, snac_p2_joy);
                @(negedge clk_74a);
                if (p2_controls !== exp_r[15:0]) report_fail("p2_controls routing wrong");
                if (game_controls[6:1] !== {exp_r[16], exp_r[17], exp_r[18], exp_r[19],
                                            exp_r[20], exp_r[31]})
                    report_fail("game_controls routing wrong");
                @(negedge clk_74a);
            end
        end
        end_test("routing");

        // coin pulse, handheld pad straight through
        write_reg(arcade_pkg::ADDR_ANALOGIZER_ENA, 32'h0);
        cont1_key = 16'h4000;
        repeat (40) @(negedge clk_74a);
        cont1_key = 16'h0000;
        high = 0;
        for (int c = 0; c < 100; c++) begin
            @(negedge clk_74a);
            if (game_controls[0]) high = high + 1;
            // press and release inside the pulse
            if (high == 5) cont1_key = 16'h4000;
            if (high == 8) cont1_key = 16'h0000;
            if (high > 0 && !game_controls[0]) break;
        end
        if (high != 32) report_fail($sformatf("coin pulse high %0d cycles", high));
        end_test("coin pulse");

        // video, then handheld screen blanked, then blank set with the adapter off
        for (int i = 0; i < 60; i++) begin
            if (i == 0 || i == 30 || i == 45) begin
                blank = (i >= 30);
                ena = (i < 45);
                write_reg(arcade_pkg::ADDR_ANALOGIZER_ENA, {31'b0, ena});
                write_reg(arcade_pkg::ADDR_SNAC_CFG, {24'b0, 7'h0, blank});
            end
            raw = rand_bits(16);
            core_video = arcade_pkg::core_video_t'(raw[15:0]);
            exp_v = exp_pixel(core_video, prev_hs, prev_vs, blank && ena);
            prev_hs = core_video.hs;
            prev_vs = core_video.vs;
            @(negedge clk_74a);
            if (pocket_video !== exp_v) report_fail("pocket_video wrong");
        end
        end_test("video");

        $display("checks done, %0d errors over %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
